// ==== Bender.yml ====
package:
  name: fetch_front

sources:
  - src/fetchPkg.sv
  - src/branchPredictor.sv
  - src/branchFourToOne.sv
  - src/fetchPcGen.sv
  - src/fetchFront.sv
  - target: test
    files:
      - verification/fetchFrontChecker.sv
      - verification/fetchFront_props.sv
      - verification/fetchFront_tb.sv

// ==== filelist.f ====
src/fetchPkg.sv
src/branchPredictor.sv
src/branchFourToOne.sv
src/fetchPcGen.sv
src/fetchFront.sv
verification/fetchFrontChecker.sv
verification/fetchFront_props.sv
verification/fetchFront_tb.sv

// ==== src/branchFourToOne.sv ====
// Branch selector that finds the first taken slot, trims enables and picks the next PC
`timescale 1ns/10ps

module branchFourToOne (
    input  fetchPkg::word_t         groupPc_i,
    input  fetchPkg::slotMask_t     originEnable_i,
    input  fetchPkg::predSlots_t    pred_i,
    output fetchPkg::selectResult_t select_o
);

    fetchPkg::slotMask_t takenEnabled;
    fetchPkg::slotMask_t firstBranch;
    fetchPkg::slotMask_t branchEnable;
    fetchPkg::word_t     alignedPc;
    fetchPkg::word_t     fifthPc;
    fetchPkg::word_t     seqPc;
    fetchPkg::word_t     branchTarget;
    logic                hasBranch;

    // ----------------------------------------
    // First enabled taken slot
    // ----------------------------------------
    assign takenEnabled = pred_i.taken & originEnable_i;
    // Isolate lowest set bit, lowest slot wins
    assign firstBranch  = takenEnabled & (~takenEnabled + 4'd1);
    assign hasBranch    = |firstBranch;

    // Keep the branch and its delay slot
    // Slot 3 branch leaves its delay slot to the next group
    always_comb begin
        if (firstBranch[0]) begin
            branchEnable = 4'b0011;
        end else if (firstBranch[1]) begin
            branchEnable = 4'b0111;
        end else begin
            branchEnable = 4'b1111;
        end
    end

    // ----------------------------------------
    // Next address
    // ----------------------------------------
    assign alignedPc = {groupPc_i[31:fetchPkg::OFFSET_W], {fetchPkg::OFFSET_W{1'b0}}};
    assign fifthPc   = alignedPc + fetchPkg::word_t'(fetchPkg::GROUP_BYTES);
    // Without slot 3 the group is a lone delay slot, fall through by one word
    assign seqPc     = originEnable_i[fetchPkg::SLOTS-1] ? fifthPc : alignedPc + 32'd4;

    // One-hot target mux
    always_comb begin
        branchTarget = '0;
        for (int s = 0; s < fetchPkg::SLOTS; s++) begin
            branchTarget = branchTarget | ({32{firstBranch[s]}} & pred_i.target[s]);
        end
    end

    assign select_o.nextPc       = hasBranch ? branchTarget : seqPc;
    assign select_o.actualEnable = branchEnable & originEnable_i;
    assign select_o.taken        = hasBranch;
    assign select_o.firstBranch  = firstBranch;

endmodule

// ==== src/branchPredictor.sv ====
// Direct-mapped branch target buffer with 2-bit counters, four slot lookups per cycle
`timescale 1ns/10ps

module branchPredictor (
    input  logic                    clk,
    input  logic                    reset_i,
    input  fetchPkg::word_t         groupPc_i,
    input  fetchPkg::branchUpdate_t update_i,
    output fetchPkg::predSlots_t    pred_o
);

    // ----------------------------------------
    // Entry storage, one line holds four slots
    // ----------------------------------------
    fetchPkg::slotMask_t validTab  [fetchPkg::BTB_LINES];
    fetchPkg::tag_t      tagTab    [fetchPkg::BTB_LINES][fetchPkg::SLOTS];
    fetchPkg::word_t     targetTab [fetchPkg::BTB_LINES][fetchPkg::SLOTS];
    fetchPkg::ctr_t      ctrTab    [fetchPkg::BTB_LINES][fetchPkg::SLOTS];

    // Lookup fields of the fetched group
    fetchPkg::btbIndex_t rdIdx;
    fetchPkg::tag_t      rdTag;

    // Update side
    fetchPkg::btbIndex_t upIdx;
    fetchPkg::slotIdx_t  upSlot;
    fetchPkg::tag_t      upTag;
    fetchPkg::ctr_t      upCtr;
    fetchPkg::ctr_t      nextCtr;
    logic                upHit;
    logic                upAlloc;
    logic                upTrain;

    // ----------------------------------------
    // Read, purely combinational
    // ----------------------------------------
    assign rdIdx = groupPc_i[fetchPkg::OFFSET_W +: fetchPkg::BTB_INDEX_W];
    assign rdTag = groupPc_i[31 -: fetchPkg::TAG_W];

    always_comb begin
        for (int s = 0; s < fetchPkg::SLOTS; s++) begin
            // Taken only on valid entry, tag hit and counter upper bit
            pred_o.taken[s]  = validTab[rdIdx][s] &&
                               (tagTab[rdIdx][s] == rdTag) &&
                               ctrTab[rdIdx][s][1];
            pred_o.target[s] = targetTab[rdIdx][s];
        end
    end

    // ----------------------------------------
    // Update from branch resolution
    // ----------------------------------------
    assign upIdx  = update_i.pc[fetchPkg::OFFSET_W +: fetchPkg::BTB_INDEX_W];
    // Word slot within the group
    assign upSlot = update_i.pc[3:2];
    assign upTag  = update_i.pc[31 -: fetchPkg::TAG_W];
    assign upHit  = validTab[upIdx][upSlot] && (tagTab[upIdx][upSlot] == upTag);
    assign upCtr  = ctrTab[upIdx][upSlot];

    // Saturating step in the resolved direction
    always_comb begin
        if (update_i.taken) begin
            nextCtr = (upCtr == 2'b11) ? upCtr : upCtr + 2'd1;
        end else begin
            nextCtr = (upCtr == 2'b00) ? upCtr : upCtr - 2'd1;
        end
    end

    // Miss plus not taken leaves the table alone
    assign upAlloc = update_i.valid && !upHit && update_i.taken;
    assign upTrain = update_i.valid && upHit;

    // Valid bits are the only control state
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int l = 0; l < fetchPkg::BTB_LINES; l++) begin
                validTab[l] <= '0;
            end
        end else if (upAlloc) begin
            validTab[upIdx][upSlot] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upAlloc) begin
            // New entry starts weakly taken
            tagTab[upIdx][upSlot]    <= upTag;
            targetTab[upIdx][upSlot] <= update_i.target;
            ctrTab[upIdx][upSlot]    <= 2'b10;
        end else if (upTrain) begin
            ctrTab[upIdx][upSlot] <= nextCtr;
            // Refresh target on a taken resolution
            if (update_i.taken) begin
                targetTab[upIdx][upSlot] <= update_i.target;
            end
        end
    end

endmodule

// ==== src/fetchFront.sv ====
// Fetch-address stage top joining PC generator, target buffer and branch selector
`timescale 1ns/10ps

module fetchFront (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    stall_i,
    input  logic                    redirect_i,
    input  fetchPkg::word_t         redirectPc_i,
    input  fetchPkg::branchUpdate_t update_i,
    output fetchPkg::fetchGroup_t   fetchGroup_o,
    output logic                    fetchValid_o
);

    fetchPkg::word_t         groupPc;
    fetchPkg::slotMask_t     originEnable;
    logic                    delaySlotOnly;
    fetchPkg::predSlots_t    pred;
    fetchPkg::selectResult_t select;

    // ----------------------------------------
    // Stage blocks
    // ----------------------------------------
    fetchPcGen pcGen (
        .clk             (clk),
        .reset_i         (reset_i),
        .stall_i         (stall_i),
        .redirect_i      (redirect_i),
        .redirectPc_i    (redirectPc_i),
        .select_i        (select),
        .groupPc_o       (groupPc),
        .originEnable_o  (originEnable),
        .delaySlotOnly_o (delaySlotOnly),
        .fetchValid_o    (fetchValid_o)
    );

    // Lookup follows the current group in the same cycle
    branchPredictor predictor (
        .clk       (clk),
        .reset_i   (reset_i),
        .groupPc_i (groupPc),
        .update_i  (update_i),
        .pred_o    (pred)
    );

    branchFourToOne selector (
        .groupPc_i      (groupPc),
        .originEnable_i (originEnable),
        .pred_i         (pred),
        .select_o       (select)
    );

    // Output group
    always_comb begin
        fetchGroup_o.pc            = groupPc;
        fetchGroup_o.enable        = select.actualEnable;
        fetchGroup_o.taken         = select.taken;
        fetchGroup_o.target        = select.nextPc;
        fetchGroup_o.delaySlotOnly = delaySlotOnly;
    end

endmodule

// ==== src/fetchPcGen.sv ====
// Fetch PC register with alignment mask and delay-slot-only sequencing
`timescale 1ns/10ps

module fetchPcGen (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    stall_i,
    input  logic                    redirect_i,
    input  fetchPkg::word_t         redirectPc_i,
    input  fetchPkg::selectResult_t select_i,
    output fetchPkg::word_t         groupPc_o,
    output fetchPkg::slotMask_t     originEnable_o,
    output logic                    delaySlotOnly_o,
    output logic                    fetchValid_o
);

    // START is the single idle cycle after reset
    typedef enum logic [1:0] {
        START,
        RUN,
        DELAY_SLOT
    } pcState_e;

    pcState_e            pcState;
    fetchPkg::word_t     fetchPc;
    // Branch target held across the delay-slot group
    fetchPkg::word_t     pendingTarget;
    fetchPkg::word_t     delaySlotPc;
    fetchPkg::slotIdx_t  startSlot;
    logic                advance;
    logic                enterDelaySlot;

    // ----------------------------------------
    // Group address and origin mask
    // ----------------------------------------
    assign groupPc_o   = {fetchPc[31:fetchPkg::OFFSET_W], {fetchPkg::OFFSET_W{1'b0}}};
    assign startSlot   = fetchPc[3:2];
    assign delaySlotPc = groupPc_o + fetchPkg::word_t'(fetchPkg::GROUP_BYTES);

    // Ones from the start slot upward, lone slot 0 for a delay slot
    assign originEnable_o = (pcState == DELAY_SLOT) ? fetchPkg::slotMask_t'(1) :
                            fetchPkg::slotMask_t'({fetchPkg::SLOTS{1'b1}} << startSlot);

    assign delaySlotOnly_o = (pcState == DELAY_SLOT);
    assign fetchValid_o    = (pcState != START);

    // Normal group accepted this cycle
    assign advance        = !redirect_i && !stall_i && (pcState == RUN);
    // Branch in slot 3 defers its target by one group
    assign enterDelaySlot = advance && select_i.firstBranch[fetchPkg::SLOTS-1];

    // ----------------------------------------
    // PC and state update
    // ----------------------------------------
    // Priority is redirect, then stall, then prediction
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pcState <= START;
            fetchPc <= fetchPkg::RESET_PC;
        end else if (redirect_i) begin
            // Also drops any pending delay slot
            pcState <= RUN;
            fetchPc <= redirectPc_i;
        end else if (pcState == START) begin
            pcState <= RUN;
        end else if (!stall_i) begin
            if (pcState == DELAY_SLOT) begin
                pcState <= RUN;
                fetchPc <= pendingTarget;
            end else if (enterDelaySlot) begin
                pcState <= DELAY_SLOT;
                fetchPc <= delaySlotPc;
            end else begin
                fetchPc <= select_i.nextPc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (enterDelaySlot) begin
            pendingTarget <= select_i.nextPc;
        end
    end

endmodule

// ==== src/fetchPkg.sv ====
// Fetch stage package with sizes, reset PC and the bundles passed between blocks
package fetchPkg;

    // ----------------------------------------
    // Group and table sizes
    // ----------------------------------------
    localparam int SLOTS       = 4;
    localparam int GROUP_BYTES = 16;
    // Byte offset bits inside one group
    localparam int OFFSET_W    = $clog2(GROUP_BYTES);
    localparam int BTB_LINES   = 16;
    localparam int BTB_INDEX_W = 4;
    // Group address bits above index and offset
    localparam int TAG_W       = 32 - BTB_INDEX_W - OFFSET_W;

    // ----------------------------------------
    // Plain vector types
    // ----------------------------------------
    typedef logic [31:0]                   word_t;
    // Bit 0 is the lowest address in the group
    typedef logic [SLOTS-1:0]              slotMask_t;
    typedef logic [$clog2(SLOTS)-1:0]      slotIdx_t;
    // Saturating direction counter, upper bit means taken
    typedef logic [1:0]                    ctr_t;
    typedef logic [BTB_INDEX_W-1:0]        btbIndex_t;
    typedef logic [TAG_W-1:0]              tag_t;

    // Boot vector, unaligned on purpose so the first group starts at slot 1
    localparam word_t RESET_PC = 32'hBFC00004;

    // ----------------------------------------
    // Bundles
    // ----------------------------------------
    // Predictor to selector
    typedef struct packed {
        slotMask_t         taken;
        word_t [SLOTS-1:0] target;
    } predSlots_t;

    // Branch resolution strobe from the backend
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t target;
        logic  taken;
    } branchUpdate_t;

    // Group presented by the stage
    typedef struct packed {
        word_t     pc;
        slotMask_t enable;
        logic      taken;
        word_t     target;
        logic      delaySlotOnly;
    } fetchGroup_t;

    // Selector to PC generator and top
    typedef struct packed {
        word_t     nextPc;
        slotMask_t actualEnable;
        logic      taken;
        slotMask_t firstBranch;
    } selectResult_t;

endpackage

// ==== verification/fetchFrontChecker.sv ====
// Scoreboard comparing each accepted fetch group with the queue of expected groups
`timescale 1ns/10ps

module fetchFrontChecker (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  stall_i,
    input  logic                  fetchValid_i,
    input  fetchPkg::fetchGroup_t group_i,
    input  logic                  expPush_i,
    input  fetchPkg::fetchGroup_t expGroup_i,
    output int                    checkCount_o,
    output int                    errorCount_o,
    output int                    pendingCount_o
);

    // Expected groups in fetch order
    fetchPkg::fetchGroup_t expQ[$];
    fetchPkg::fetchGroup_t expected;
    // Set once the START cycle after reset has gone by
    logic                  pastStart;

    // ----------------------------------------
    // Field compare
    // ----------------------------------------
    task automatic compareField(string name, logic [31:0] want, logic [31:0] got,
                                fetchPkg::word_t groupPc);
        if (want !== got) begin
            $display("ERR %0t: group %h field %s expected %h got %h",
                     $time, groupPc, name, want, got);
            errorCount_o++;
        end
    endtask

    // ----------------------------------------
    // Sampling
    // ----------------------------------------
    // A group counts as fetched when valid and not stalled at the edge
    always @(posedge clk) begin
        if (reset_i) begin
            expQ.delete();
            checkCount_o = 0;
            errorCount_o = 0;
            pastStart    = 1'b0;
        end else begin
            // Valid is low only in the START cycle, high every cycle after it
            if (fetchValid_i !== pastStart) begin
                $display("ERR %0t: fetchValid expected %b got %b",
                         $time, pastStart, fetchValid_i);
                errorCount_o++;
            end
            pastStart = 1'b1;
            if (expPush_i) begin
                expQ.push_back(expGroup_i);
            end
            if (fetchValid_i && !stall_i) begin
                if (expQ.size() == 0) begin
                    $display("ERR %0t: group %h fetched with no expected entry",
                             $time, group_i.pc);
                    errorCount_o++;
                end else begin
                    expected = expQ.pop_front();
                    checkCount_o++;
                    compareField("pc", expected.pc, group_i.pc, expected.pc);
                    compareField("enable", expected.enable, group_i.enable, expected.pc);
                    compareField("taken", expected.taken, group_i.taken, expected.pc);
                    compareField("target", expected.target, group_i.target, expected.pc);
                    compareField("delaySlotOnly", expected.delaySlotOnly,
                                 group_i.delaySlotOnly, expected.pc);
                end
            end
        end
        pendingCount_o = expQ.size();
    end

endmodule

// ==== verification/fetchFront_props.sv ====
// Bound assertions on selector results and fetch PC sequencing
`timescale 1ns/10ps

module fetchFrontProps (
    input logic                    clk,
    input logic                    reset_i,
    input logic                    stall_i,
    input logic                    redirect_i,
    input logic                    fetchValid_i,
    input logic                    delaySlot_i,
    input fetchPkg::word_t         fetchPc_i,
    input fetchPkg::slotMask_t     originEnable_i,
    input fetchPkg::selectResult_t select_i
);

    // Failure tally read at the end of the run
    int assertFails = 0;

    // ----------------------------------------
    // Selector results
    // ----------------------------------------
    firstBranchOneHot: assert property (@(posedge clk) disable iff (reset_i)
        fetchValid_i |-> $onehot0(select_i.firstBranch))
        else begin
            assertFails++;
            $error("first branch mask has more than one slot set");
        end

    // Trimming only ever removes slots
    enableSubset: assert property (@(posedge clk) disable iff (reset_i)
        fetchValid_i |-> ((select_i.actualEnable & ~originEnable_i) == '0))
        else begin
            assertFails++;
            $error("group enables slots outside the origin mask");
        end

    // ----------------------------------------
    // PC generator sequencing
    // ----------------------------------------
    // Enable of the presented group after selector trimming
    delaySlotMask: assert property (@(posedge clk) disable iff (reset_i)
        delaySlot_i |-> (select_i.actualEnable == 4'b0001))
        else begin
            assertFails++;
            $error("delay-slot-only group does not enable slot 0 alone");
        end

    // Held group and held delay-slot flag
    stallHolds: assert property (@(posedge clk) disable iff (reset_i)
        (fetchValid_i && stall_i && !redirect_i) |=>
            ($stable(fetchPc_i) && $stable(delaySlot_i)))
        else begin
            assertFails++;
            $error("fetch PC moved while the stage was stalled");
        end

endmodule

bind fetchPcGen fetchFrontProps fetchProps (
    .clk            (clk),
    .reset_i        (reset_i),
    .stall_i        (stall_i),
    .redirect_i     (redirect_i),
    .fetchValid_i   (fetchValid_o),
    .delaySlot_i    (delaySlotOnly_o),
    .fetchPc_i      (fetchPc),
    .originEnable_i (originEnable_o),
    .select_i       (select_i)
);

// ==== verification/fetchFront_tb.sv ====
// Testbench for the fetch-address stage driven from a command and expectation file
`timescale 1ns/10ps

module fetchFront_tb;

    localparam int VALID_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 50;

    logic                    clk = 1'b0;
    logic                    reset;
    logic                    stall;
    logic                    redirect;
    fetchPkg::word_t         redirectPc;
    fetchPkg::branchUpdate_t branchUpd;
    fetchPkg::fetchGroup_t   fetchGroup;
    logic                    fetchValid;

    // Expected groups handed to the checker
    logic                    expPush;
    fetchPkg::fetchGroup_t   expGroup;
    int                      checkCount;
    int                      checkErrors;
    int                      pendingCount;
    int                      benchErrors = 0;
    logic                    aborted = 1'b0;

    always #2 clk = ~clk;

    fetchFront dut_i (
        .clk          (clk),
        .reset_i      (reset),
        .stall_i      (stall),
        .redirect_i   (redirect),
        .redirectPc_i (redirectPc),
        .update_i     (branchUpd),
        .fetchGroup_o (fetchGroup),
        .fetchValid_o (fetchValid)
    );

    fetchFrontChecker groupCheck (
        .clk            (clk),
        .reset_i        (reset),
        .stall_i        (stall),
        .fetchValid_i   (fetchValid),
        .group_i        (fetchGroup),
        .expPush_i      (expPush),
        .expGroup_i     (expGroup),
        .checkCount_o   (checkCount),
        .errorCount_o   (checkErrors),
        .pendingCount_o (pendingCount)
    );

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // One-cycle strobes and a resting stall between runs
    task automatic restStrobes();
        stall           <= 1'b1;
        redirect        <= 1'b0;
        branchUpd.valid <= 1'b0;
        expPush         <= 1'b0;
    endtask

    task automatic flagBadLine(string line);
        $display("Malformed or unknown line in test file: %s", line);
        benchErrors++;
    endtask

    task automatic runCommands();
        int                  fd;
        int                  waited;
        int                  fields;
        int                  count;
        int                  takenBit;
        int                  dsBit;
        string               line;
        string               cmd;
        fetchPkg::word_t     pcVal;
        fetchPkg::word_t     tgtVal;
        fetchPkg::slotMask_t enVal;

        fd = $fopen("verification/fetchFront_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open verification/fetchFront_tests.txt");
            aborted = 1'b1;
            return;
        end
        // Valid stays low for the START cycle only
        waited = 0;
        while (!fetchValid && waited < VALID_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!fetchValid) begin
            $display("Timed out waiting for fetchValid_o after reset");
            aborted = 1'b1;
            $fclose(fd);
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            fields = $sscanf(line, "%s", cmd);
            if (fields < 1 || cmd.substr(0, 0) == "#") begin
                continue;
            end
            @(posedge clk);
            restStrobes();
            if (cmd == "update") begin
                fields = $sscanf(line, "%s %h %h %d", cmd, pcVal, tgtVal, takenBit);
                if (fields != 4) flagBadLine(line);
                branchUpd <= '{valid: 1'b1, pc: pcVal, target: tgtVal, taken: takenBit[0]};
            end else if (cmd == "redirect") begin
                fields = $sscanf(line, "%s %h", cmd, pcVal);
                if (fields != 2) flagBadLine(line);
                redirect   <= 1'b1;
                redirectPc <= pcVal;
            end else if (cmd == "stall" || cmd == "run") begin
                fields = $sscanf(line, "%s %d", cmd, count);
                if (fields != 2) flagBadLine(line);
                if (cmd == "run") stall <= 1'b0;
                // Next command's edge ends the window
                repeat (count - 1) @(posedge clk);
            end else if (cmd == "expect") begin
                fields = $sscanf(line, "%s %h %b %d %h %d",
                                 cmd, pcVal, enVal, takenBit, tgtVal, dsBit);
                if (fields != 6) flagBadLine(line);
                expGroup <= '{pc: pcVal, enable: enVal, taken: takenBit[0],
                              target: tgtVal, delaySlotOnly: dsBit[0]};
                expPush  <= 1'b1;
            end else begin
                flagBadLine(line);
            end
        end
        @(posedge clk);
        restStrobes();
        $fclose(fd);
    endtask

    // Every expected group must have been fetched
    task automatic waitForDrain();
        int waited;

        waited = 0;
        @(negedge clk);
        while (pendingCount != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (pendingCount != 0) begin
            $display("Timed out with %0d expected groups never fetched", pendingCount);
            aborted = 1'b1;
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int totalErrors;

        reset      <= 1'b1;
        stall      <= 1'b1;
        redirect   <= 1'b0;
        redirectPc <= '0;
        branchUpd  <= '0;
        expPush    <= 1'b0;
        expGroup   <= '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        runCommands();
        if (!aborted) begin
            waitForDrain();
        end
        totalErrors = checkErrors + benchErrors + dut_i.pcGen.fetchProps.assertFails;
        $display("Checks %0d, check errors %0d, bench errors %0d, assertion failures %0d",
                 checkCount, checkErrors, benchErrors, dut_i.pcGen.fetchProps.assertFails);
        if (aborted || totalErrors != 0) begin
            $display("FAIL: see errors above");
        end else begin
            $display("PASS: all tests");
        end
        $finish;
    end

endmodule

// ==== verification/fetchFront_tests.txt ====
# Command lines are update <pc> <target> <taken>, redirect <pc>, stall <n>, run <n>
# expect <group pc> <enable with slot 3 leftmost> <taken> <next pc> <delay slot only>
# Sequential fetch from reset
expect BFC00000 1110 0 BFC00010 0
expect BFC00010 1111 0 BFC00020 0
expect BFC00020 1111 0 BFC00030 0
run 3
# Slot 1 branch trims the group to 0111 and the target group keeps its mask
update BFC00044 BFC00108 1
expect BFC00030 1111 0 BFC00040 0
expect BFC00040 0111 1 BFC00108 0
expect BFC00100 1100 0 BFC00110 0
run 3
# Slot 3 branch then a lone delay slot then the held target
update BFC0011C BFC00200 1
expect BFC00110 1111 1 BFC00200 0
expect BFC00120 0001 0 BFC00124 1
expect BFC00200 1111 0 BFC00210 0
run 3
# Redirect behind the slot 1 branch leaves it out of the group
redirect BFC00048
expect BFC00040 1100 0 BFC00050 0
run 1
# Redirect to offset 8 drops the pending delay slot
redirect BFC00110
expect BFC00110 1111 1 BFC00200 0
run 1
redirect BFC00308
expect BFC00300 1100 0 BFC00310 0
expect BFC00310 1111 0 BFC00320 0
run 2
# One not-taken update after allocation stops the prediction
redirect BFC00400
update BFC00400 BFC00500 1
update BFC00400 BFC00500 0
expect BFC00400 1111 0 BFC00410 0
run 1
# Two taken then one not-taken still predicts taken
update BFC00400 BFC00500 1
update BFC00400 BFC00500 1
update BFC00400 BFC00500 0
redirect BFC00400
expect BFC00400 0011 1 BFC00500 0
expect BFC00500 1111 0 BFC00510 0
run 2
# Stall holds the shown group and a redirect under stall wins on the next edge
stall 5
expect BFC00510 1111 0 BFC00520 0
run 1
stall 3
redirect BFC0060C
stall 2
expect BFC00600 1000 0 BFC00610 0
expect BFC00610 1111 0 BFC00620 0
run 2
